// ==== Bender.yml ====
package:
  name: axi_mux

sources:
  - files:
      - source/axi_mux_pkg.sv
      - source/axi_spill_reg.sv
      - source/axi_aw_arbiter.sv
      - source/axi_w_route_fifo.sv
      - source/axi_w_steer.sv
      - source/axi_b_router.sv
      - source/axi_mux_top.sv
  - target: test
    files:
      - tb/axi_mux_sva.sv
      - tb/tb_axi_mux.sv

# The testbench reads tb/axi_mux_vectors.txt at run time, from the project root

// ==== project.f ====
source/axi_mux_pkg.sv
source/axi_spill_reg.sv
source/axi_aw_arbiter.sv
source/axi_w_route_fifo.sv
source/axi_w_steer.sv
source/axi_b_router.sv
source/axi_mux_top.sv
tb/axi_mux_sva.sv
tb/tb_axi_mux.sv

// ==== source/axi_aw_arbiter.sv ====
`timescale 1ns/1ps

module axi_aw_arbiter (
  input  logic                                                      clk_i,
  input  logic                                                      rst_i,
  input  logic [axi_mux_pkg::NUM_PORTS-1:0]                         slv_aw_valid_i,
  output logic [axi_mux_pkg::NUM_PORTS-1:0]                         slv_aw_ready_o,
  input  axi_mux_pkg::slv_id_t [axi_mux_pkg::NUM_PORTS-1:0]         slv_aw_id_i,
  input  logic [axi_mux_pkg::NUM_PORTS-1:0][axi_mux_pkg::ADDR_W-1:0] slv_aw_addr_i,
  input  logic [axi_mux_pkg::NUM_PORTS-1:0][axi_mux_pkg::LEN_W-1:0]  slv_aw_len_i,
  output logic                                                      aw_valid_o,
  input  logic                                                      aw_ready_i,
  output axi_mux_pkg::aw_chan_t                                     aw_chan_o,
  input  logic                                                      fifo_full_i,
  output logic                                                      fifo_push_o,
  output axi_mux_pkg::port_idx_t                                    fifo_idx_o
);

  axi_mux_pkg::port_idx_t rr_q;            // Port with highest priority
  axi_mux_pkg::port_idx_t sel_idx;
  axi_mux_pkg::port_idx_t lock_idx_q;
  axi_mux_pkg::port_idx_t aw_idx;
  logic                   sel_valid;
  logic                   lock_q, lock_d;
  logic                   aw_accept;

  // ------------------------------
  // Round-robin selection
  // ------------------------------
  always_comb begin
    sel_valid = 1'b0;
    sel_idx   = rr_q;
    for (int i = 0; i < axi_mux_pkg::NUM_PORTS; i++) begin
      if (!sel_valid && slv_aw_valid_i[(int'(rr_q) + i) % axi_mux_pkg::NUM_PORTS]) begin
        sel_valid = 1'b1;
        sel_idx   = axi_mux_pkg::port_idx_t'((int'(rr_q) + i) % axi_mux_pkg::NUM_PORTS);
      end
    end
  end

  assign aw_idx = lock_q ? lock_idx_q : sel_idx;  // Held grant wins

  // ------------------------------
  // Offer and push control
  // ------------------------------
  always_comb begin
    aw_valid_o  = 1'b0;
    fifo_push_o = 1'b0;
    lock_d      = lock_q;
    if (lock_q) begin
      aw_valid_o = 1'b1;                     // Decision already pushed
      if (aw_ready_i) lock_d = 1'b0;
    end else if (sel_valid && !fifo_full_i) begin
      aw_valid_o  = 1'b1;
      fifo_push_o = 1'b1;
      if (!aw_ready_i) lock_d = 1'b1;
    end
  end

  assign aw_accept  = aw_valid_o && aw_ready_i;
  assign fifo_idx_o = aw_idx;

  always_comb begin
    slv_aw_ready_o         = '0;
    slv_aw_ready_o[aw_idx] = aw_accept;
  end

  // Prepend the port index to the ID
  assign aw_chan_o.id   = {aw_idx, slv_aw_id_i[aw_idx]};
  assign aw_chan_o.addr = slv_aw_addr_i[aw_idx];
  assign aw_chan_o.len  = slv_aw_len_i[aw_idx];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rr_q       <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else begin
      lock_q <= lock_d;
      if (!lock_q) lock_idx_q <= sel_idx;
      if (aw_accept) rr_q <= axi_mux_pkg::port_idx_t'((int'(aw_idx) + 1) % axi_mux_pkg::NUM_PORTS);
    end
  end

endmodule

// ==== source/axi_b_router.sv ====
`timescale 1ns/1ps

module axi_b_router (
  input  logic                                               clk_i,
  input  logic                                               rst_i,
  input  logic                                               mst_b_valid_i,
  output logic                                               mst_b_ready_o,
  input  axi_mux_pkg::mst_id_t                               mst_b_id_i,
  input  axi_mux_pkg::resp_t                                 mst_b_resp_i,
  output logic [axi_mux_pkg::NUM_PORTS-1:0]                  slv_b_valid_o,
  input  logic [axi_mux_pkg::NUM_PORTS-1:0]                  slv_b_ready_i,
  output axi_mux_pkg::slv_id_t [axi_mux_pkg::NUM_PORTS-1:0]  slv_b_id_o,
  output axi_mux_pkg::resp_t [axi_mux_pkg::NUM_PORTS-1:0]    slv_b_resp_o
);

  axi_mux_pkg::b_chan_t   b_in, b_q;
  logic                   b_valid;
  axi_mux_pkg::port_idx_t route_idx;

  assign b_in.id   = mst_b_id_i;
  assign b_in.resp = mst_b_resp_i;

  axi_spill_reg #(
    .T ( axi_mux_pkg::b_chan_t )
  ) i_b_spill (
    .clk_i   ( clk_i                     ),
    .rst_i   ( rst_i                     ),
    .valid_i ( mst_b_valid_i             ),
    .ready_o ( mst_b_ready_o             ),
    .data_i  ( b_in                      ),
    .valid_o ( b_valid                   ),
    .ready_i ( slv_b_ready_i[route_idx]  ),
    .data_o  ( b_q                       )
  );

  // Top ID bits name the issuing port
  assign route_idx = b_q.id[axi_mux_pkg::MST_ID_W-1 -: axi_mux_pkg::PORT_IDX_W];

  for (genvar i = 0; i < axi_mux_pkg::NUM_PORTS; i++) begin : gen_b_port
    assign slv_b_valid_o[i] = b_valid && (route_idx == axi_mux_pkg::port_idx_t'(i));
    assign slv_b_id_o[i]    = b_q.id[axi_mux_pkg::SLV_ID_W-1:0];  // Index stripped
    assign slv_b_resp_o[i]  = b_q.resp;
  end

endmodule

// ==== source/axi_mux_pkg.sv ====
package axi_mux_pkg;

  // ------------------------------
  // Port count and widths
  // ------------------------------
  localparam int unsigned NUM_PORTS  = 2;
  localparam int unsigned PORT_IDX_W = $clog2(NUM_PORTS);
  localparam int unsigned SLV_ID_W   = 2;
  localparam int unsigned MST_ID_W   = SLV_ID_W + PORT_IDX_W; // Port index on top
  localparam int unsigned ADDR_W     = 16;
  localparam int unsigned DATA_W     = 16;
  localparam int unsigned LEN_W      = 4;

  // Route FIFO depth bounds the writes with data still pending
  localparam int unsigned MAX_W_TRANS  = 4;
  localparam int unsigned W_FIFO_PTR_W = $clog2(MAX_W_TRANS);
  localparam int unsigned W_FIFO_CNT_W = $clog2(MAX_W_TRANS + 1);

  typedef logic [PORT_IDX_W-1:0] port_idx_t;
  typedef logic [SLV_ID_W-1:0]   slv_id_t;
  typedef logic [MST_ID_W-1:0]   mst_id_t;
  typedef logic [1:0]            resp_t;

  // Master side channel payloads
  typedef struct packed {
    mst_id_t             id;
    logic [ADDR_W-1:0]   addr;
    logic [LEN_W-1:0]    len;
  } aw_chan_t;                   // 23 bits

  typedef struct packed {
    mst_id_t id;
    resp_t   resp;
  } b_chan_t;                    // 5 bits

endpackage

// ==== source/axi_mux_top.sv ====
`timescale 1ns/1ps

module axi_mux_top (
  input  logic                                                      clk_i,
  input  logic                                                      rst_i,
  // Slave ports
  input  logic [axi_mux_pkg::NUM_PORTS-1:0]                         slv_aw_valid_i,
  output logic [axi_mux_pkg::NUM_PORTS-1:0]                         slv_aw_ready_o,
  input  axi_mux_pkg::slv_id_t [axi_mux_pkg::NUM_PORTS-1:0]         slv_aw_id_i,
  input  logic [axi_mux_pkg::NUM_PORTS-1:0][axi_mux_pkg::ADDR_W-1:0] slv_aw_addr_i,
  input  logic [axi_mux_pkg::NUM_PORTS-1:0][axi_mux_pkg::LEN_W-1:0]  slv_aw_len_i,
  input  logic [axi_mux_pkg::NUM_PORTS-1:0]                         slv_w_valid_i,
  output logic [axi_mux_pkg::NUM_PORTS-1:0]                         slv_w_ready_o,
  input  logic [axi_mux_pkg::NUM_PORTS-1:0][axi_mux_pkg::DATA_W-1:0] slv_w_data_i,
  input  logic [axi_mux_pkg::NUM_PORTS-1:0]                         slv_w_last_i,
  output logic [axi_mux_pkg::NUM_PORTS-1:0]                         slv_b_valid_o,
  input  logic [axi_mux_pkg::NUM_PORTS-1:0]                         slv_b_ready_i,
  output axi_mux_pkg::slv_id_t [axi_mux_pkg::NUM_PORTS-1:0]         slv_b_id_o,
  output axi_mux_pkg::resp_t [axi_mux_pkg::NUM_PORTS-1:0]           slv_b_resp_o,
  // Master port
  output logic                                                      mst_aw_valid_o,
  input  logic                                                      mst_aw_ready_i,
  output axi_mux_pkg::mst_id_t                                      mst_aw_id_o,
  output logic [axi_mux_pkg::ADDR_W-1:0]                            mst_aw_addr_o,
  output logic [axi_mux_pkg::LEN_W-1:0]                             mst_aw_len_o,
  output logic                                                      mst_w_valid_o,
  input  logic                                                      mst_w_ready_i,
  output logic [axi_mux_pkg::DATA_W-1:0]                            mst_w_data_o,
  output logic                                                      mst_w_last_o,
  input  logic                                                      mst_b_valid_i,
  output logic                                                      mst_b_ready_o,
  input  axi_mux_pkg::mst_id_t                                      mst_b_id_i,
  input  axi_mux_pkg::resp_t                                        mst_b_resp_i
);

  axi_mux_pkg::aw_chan_t  aw_chan, mst_aw_chan;
  logic                   aw_valid, aw_ready;
  logic                   fifo_push, fifo_pop, fifo_full, fifo_empty;
  axi_mux_pkg::port_idx_t fifo_idx, head_idx;

  // ------------------------------
  // AW path
  // ------------------------------
  axi_aw_arbiter i_aw_arbiter (
    .clk_i, .rst_i, .slv_aw_valid_i, .slv_aw_ready_o, .slv_aw_id_i, .slv_aw_addr_i,
    .slv_aw_len_i,
    .aw_valid_o  ( aw_valid  ),
    .aw_ready_i  ( aw_ready  ),
    .aw_chan_o   ( aw_chan   ),
    .fifo_full_i ( fifo_full ),
    .fifo_push_o ( fifo_push ),
    .fifo_idx_o  ( fifo_idx  )
  );

  axi_spill_reg #(.T(axi_mux_pkg::aw_chan_t)) i_aw_spill (
    .clk_i, .rst_i,
    .valid_i ( aw_valid ), .ready_o ( aw_ready ), .data_i ( aw_chan ),
    .valid_o ( mst_aw_valid_o ), .ready_i ( mst_aw_ready_i ), .data_o ( mst_aw_chan )
  );

  assign mst_aw_id_o   = mst_aw_chan.id;
  assign mst_aw_addr_o = mst_aw_chan.addr;
  assign mst_aw_len_o  = mst_aw_chan.len;

  // ------------------------------
  // W path steered by AW order
  // ------------------------------
  axi_w_route_fifo i_w_fifo (
    .clk_i, .rst_i,
    .push_i ( fifo_push ), .data_i ( fifo_idx ), .pop_i ( fifo_pop ),
    .data_o ( head_idx ), .full_o ( fifo_full ), .empty_o ( fifo_empty )
  );

  axi_w_steer i_w_steer (
    .head_idx_i ( head_idx   ),
    .empty_i    ( fifo_empty ),
    .slv_w_valid_i, .slv_w_ready_o, .slv_w_data_i, .slv_w_last_i,
    .mst_w_valid_o, .mst_w_ready_i, .mst_w_data_o, .mst_w_last_o,
    .pop_o      ( fifo_pop   )
  );

  // B responses back to their port
  axi_b_router i_b_router (
    .clk_i, .rst_i, .mst_b_valid_i, .mst_b_ready_o, .mst_b_id_i, .mst_b_resp_i,
    .slv_b_valid_o, .slv_b_ready_i, .slv_b_id_o, .slv_b_resp_o
  );

endmodule

// ==== source/axi_spill_reg.sv ====
`timescale 1ns/1ps

module axi_spill_reg #(
  parameter type T = logic
) (
  input  logic clk_i,
  input  logic rst_i,
  input  logic valid_i,
  output logic ready_o,
  input  T     data_i,
  output logic valid_o,
  input  logic ready_i,
  output T     data_o
);

  // Slot A takes new data, slot B catches it on a downstream stall
  logic a_full_q, b_full_q;
  T     a_data_q, b_data_q;
  logic a_fill, a_drain, b_fill, b_drain;

  assign a_fill  = valid_i && ready_o;
  assign a_drain = a_full_q && !b_full_q;  // To output or into B
  assign b_fill  = a_drain && !ready_i;
  assign b_drain = b_full_q && ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      if (a_fill || a_drain) a_full_q <= a_fill;
      if (b_fill || b_drain) b_full_q <= b_fill;
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fill) a_data_q <= data_i;
    if (b_fill) b_data_q <= a_data_q;
  end

  assign ready_o = !a_full_q || !b_full_q;
  assign valid_o = a_full_q || b_full_q;
  assign data_o  = b_full_q ? b_data_q : a_data_q;  // B holds the older entry

endmodule

// ==== source/axi_w_route_fifo.sv ====
`timescale 1ns/1ps

module axi_w_route_fifo (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   push_i,
  input  axi_mux_pkg::port_idx_t data_i,
  input  logic                   pop_i,
  output axi_mux_pkg::port_idx_t data_o,
  output logic                   full_o,
  output logic                   empty_o
);

  axi_mux_pkg::port_idx_t                  mem [axi_mux_pkg::MAX_W_TRANS];
  logic [axi_mux_pkg::W_FIFO_PTR_W-1:0]    wr_ptr_q, rd_ptr_q;
  logic [axi_mux_pkg::W_FIFO_CNT_W-1:0]    count_q;
  logic                                    do_push, do_pop;

  assign full_o  = (count_q == axi_mux_pkg::W_FIFO_CNT_W'(axi_mux_pkg::MAX_W_TRANS));
  assign empty_o = (count_q == '0);
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;
  assign data_o  = mem[rd_ptr_q];        // Head of the queue

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        if (wr_ptr_q == axi_mux_pkg::W_FIFO_PTR_W'(axi_mux_pkg::MAX_W_TRANS - 1)) wr_ptr_q <= '0;
        else wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        if (rd_ptr_q == axi_mux_pkg::W_FIFO_PTR_W'(axi_mux_pkg::MAX_W_TRANS - 1)) rd_ptr_q <= '0;
        else rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) count_q <= count_q + 1'b1;
      else if (do_pop && !do_push) count_q <= count_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) mem[wr_ptr_q] <= data_i;
  end

endmodule

// ==== source/axi_w_steer.sv ====
`timescale 1ns/1ps

module axi_w_steer (
  input  axi_mux_pkg::port_idx_t                                    head_idx_i,
  input  logic                                                      empty_i,
  input  logic [axi_mux_pkg::NUM_PORTS-1:0]                         slv_w_valid_i,
  output logic [axi_mux_pkg::NUM_PORTS-1:0]                         slv_w_ready_o,
  input  logic [axi_mux_pkg::NUM_PORTS-1:0][axi_mux_pkg::DATA_W-1:0] slv_w_data_i,
  input  logic [axi_mux_pkg::NUM_PORTS-1:0]                         slv_w_last_i,
  output logic                                                      mst_w_valid_o,
  input  logic                                                      mst_w_ready_i,
  output logic [axi_mux_pkg::DATA_W-1:0]                            mst_w_data_o,
  output logic                                                      mst_w_last_o,
  output logic                                                      pop_o
);

  // Only the port at the FIFO head may send W beats
  assign mst_w_valid_o = !empty_i && slv_w_valid_i[head_idx_i];
  assign mst_w_data_o  = slv_w_data_i[head_idx_i];
  assign mst_w_last_o  = slv_w_last_i[head_idx_i];

  always_comb begin
    slv_w_ready_o = '0;
    if (!empty_i) slv_w_ready_o[head_idx_i] = mst_w_ready_i;  // Other port stays blocked
  end

  // Pop on the accepted last beat so the next decision moves up
  assign pop_o = mst_w_valid_o && mst_w_ready_i && mst_w_last_o;

endmodule

// ==== tb/axi_mux_sva.sv ====
`timescale 1ns/1ps

module axi_mux_sva (
  input logic                                 clk_i,
  input logic                                 rst_i,
  input logic                                 mst_aw_valid_o,
  input logic                                 mst_aw_ready_i,
  input axi_mux_pkg::mst_id_t                 mst_aw_id_o,
  input logic [axi_mux_pkg::ADDR_W-1:0]       mst_aw_addr_o,
  input logic [axi_mux_pkg::LEN_W-1:0]        mst_aw_len_o,
  input logic                                 mst_w_valid_o,
  input logic                                 mst_w_ready_i,
  input logic [axi_mux_pkg::DATA_W-1:0]       mst_w_data_o,
  input logic                                 mst_w_last_o,
  input logic [axi_mux_pkg::NUM_PORTS-1:0]    slv_b_valid_o
);

  int unsigned err_count = 0;

  // ------------------------------
  // Master side handshake rules
  // ------------------------------
  aw_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    mst_aw_valid_o && !mst_aw_ready_i |=> mst_aw_valid_o &&
      $stable({mst_aw_id_o, mst_aw_addr_o, mst_aw_len_o}))
    else begin
      $error("Master AW dropped or changed before ready");
      err_count++;
    end

  w_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    mst_w_valid_o && !mst_w_ready_i |=> mst_w_valid_o &&
      $stable({mst_w_data_o, mst_w_last_o}))
    else begin
      $error("Master W dropped or changed before ready");
      err_count++;
    end

  b_onehot: assert property (@(posedge clk_i) disable iff (rst_i)
    !(slv_b_valid_o[0] && slv_b_valid_o[1]))  // Only one port gets each B
    else begin
      $error("Both slave ports show b_valid");
      err_count++;
    end

endmodule

bind axi_mux_top axi_mux_sva i_sva (.*);

// ==== tb/axi_mux_vectors.txt ====
// Columns: port slv_id addr len first_data resp exp_mst_id (all hex)
// Each later beat of a burst carries first_data plus the beat number
0 0 1000 0 a000 0 0
1 1 2000 3 b000 0 5
0 2 1040 1 a010 1 2
1 3 2100 2 b100 2 7
0 1 1080 7 a020 0 1
1 0 2200 0 b200 3 4
0 3 10c0 2 a030 2 3
1 2 2300 5 b300 0 6
0 0 1100 3 a040 3 0
1 1 2400 1 b400 1 5
0 2 1140 0 a050 0 2
1 3 2500 4 b500 2 7

// ==== tb/tb_axi_mux.sv ====
`timescale 1ns/1ps

module tb_axi_mux;

  localparam int NP     = axi_mux_pkg::NUM_PORTS;
  localparam int NV     = 12;   // Vectors in the data file
  localparam int NF     = 7;    // Fields per vector
  localparam int PERIOD = 40;

  logic                                   clk_i, rst_i;
  logic [NP-1:0]                          slv_aw_valid_i, slv_aw_ready_o;
  axi_mux_pkg::slv_id_t [NP-1:0]          slv_aw_id_i;
  logic [NP-1:0][axi_mux_pkg::ADDR_W-1:0] slv_aw_addr_i;
  logic [NP-1:0][axi_mux_pkg::LEN_W-1:0]  slv_aw_len_i;
  logic [NP-1:0]                          slv_w_valid_i, slv_w_ready_o, slv_w_last_i;
  logic [NP-1:0][axi_mux_pkg::DATA_W-1:0] slv_w_data_i;
  logic [NP-1:0]                          slv_b_valid_o, slv_b_ready_i;
  axi_mux_pkg::slv_id_t [NP-1:0]          slv_b_id_o;
  axi_mux_pkg::resp_t [NP-1:0]            slv_b_resp_o;
  logic                                   mst_aw_valid_o, mst_aw_ready_i;
  axi_mux_pkg::mst_id_t                   mst_aw_id_o, mst_b_id_i;
  logic [axi_mux_pkg::ADDR_W-1:0]         mst_aw_addr_o;
  logic [axi_mux_pkg::LEN_W-1:0]          mst_aw_len_o;
  logic                                   mst_w_valid_o, mst_w_ready_i, mst_w_last_o;
  logic [axi_mux_pkg::DATA_W-1:0]         mst_w_data_o;
  logic                                   mst_b_valid_i, mst_b_ready_o;
  axi_mux_pkg::resp_t                     mst_b_resp_i;

  logic [15:0] vec_mem [NV*NF];
  int          port_vecs [NP][$];  // Vector numbers per port in issue order
  int          aw_exp [NP][$];
  int          b_exp [NP][$];
  int          aw_order [$];       // AWs seen at the master whose burst is not done yet
  int          b_pend [$];         // Finished bursts waiting for their B
  int          aw_sent [NP];
  int          aw_xfers, w_bursts, b_seen;
  logic [31:0] lcg_state;

  axi_mux_top i_dut (.*);

  function automatic logic [15:0] fld(int v, int f);
    return vec_mem[v*NF + f];
  endfunction

  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[30:16];
  endfunction

  task automatic abort_run();
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic check_val(string name, logic [31:0] exp, logic [31:0] act);
    if (exp !== act) begin
      $display("[ERROR] %s expected 0x%0h got 0x%0h", name, exp, act);
      abort_run();
    end
  endtask

  // ------------------------------
  // Upstream masters
  // ------------------------------
  task automatic send_aw(int p, int v);
    slv_aw_valid_i[p] = 1'b1;
    slv_aw_id_i[p]    = axi_mux_pkg::slv_id_t'(fld(v, 1));
    slv_aw_addr_i[p]  = fld(v, 2);
    slv_aw_len_i[p]   = axi_mux_pkg::LEN_W'(fld(v, 3));
    do @(posedge clk_i); while (!slv_aw_ready_o[p]);
    aw_sent[p]++;
    #2 slv_aw_valid_i[p] = 1'b0;
    repeat (lcg_next() % 3) begin
      @(posedge clk_i);
      #2;
    end
  endtask

  task automatic send_w(int p, int v);
    for (int k = 0; k <= fld(v, 3); k++) begin
      slv_w_valid_i[p] = 1'b1;
      slv_w_data_i[p]  = fld(v, 4) + 16'(k);  // Beats count up
      slv_w_last_i[p]  = (k == fld(v, 3));
      do @(posedge clk_i); while (!slv_w_ready_o[p]);
      #2 slv_w_valid_i[p] = 1'b0;
    end
  endtask

  task automatic run_port(int p);
    fork
      for (int i = 0; i < port_vecs[p].size(); i++) send_aw(p, port_vecs[p][i]);
      begin
        wait (aw_sent[0] > 0 && aw_sent[1] > 0);  // Both ports get AWs outstanding first
        @(posedge clk_i);
        #2;
        for (int i = 0; i < port_vecs[p].size(); i++) send_w(p, port_vecs[p][i]);
      end
    join
  endtask

  // ------------------------------
  // Downstream slave and checks
  // ------------------------------
  initial begin
    int          v;
    int          p;
    int          beat;
    logic [15:0] exp_data;
    beat = 0;
    forever begin
      @(posedge clk_i);
      if (mst_aw_valid_o && mst_aw_ready_i) begin
        p = mst_aw_id_o[axi_mux_pkg::MST_ID_W-1];
        if (aw_exp[p].size() == 0) begin
          $display("A master AW arrived for port %0d with no write left to match", p);
          abort_run();
        end
        v = aw_exp[p].pop_front();
        check_val("mst_aw_id_o", fld(v, 6), mst_aw_id_o);
        check_val("mst_aw_addr_o", fld(v, 2), mst_aw_addr_o);
        check_val("mst_aw_len_o", fld(v, 3), mst_aw_len_o);
        aw_order.push_back(v);
        aw_xfers++;
      end
      if (mst_w_valid_o && mst_w_ready_i) begin
        if (aw_order.size() == 0) begin
          $display("A master W beat was accepted with no address to belong to");
          abort_run();
        end
        v        = aw_order[0];
        exp_data = fld(v, 4) + 16'(beat);
        check_val("mst_w_data_o", exp_data, mst_w_data_o);
        check_val("mst_w_last_o", beat == fld(v, 3), mst_w_last_o);
        if (mst_w_last_o) begin
          beat = 0;
          void'(aw_order.pop_front());
          b_pend.push_back(v);
          w_bursts++;
        end else begin
          beat++;
        end
      end
      if (aw_xfers > w_bursts + axi_mux_pkg::MAX_W_TRANS + 2) begin
        $display("Too many writes outstanding, %0d AWs against %0d bursts", aw_xfers, w_bursts);
        abort_run();
      end
      for (int q = 0; q < NP; q++) begin
        if (slv_b_valid_o[q] && slv_b_ready_i[q]) begin
          if (b_exp[q].size() == 0) begin
            $display("Port %0d received a B response it did not expect", q);
            abort_run();
          end
          v = b_exp[q].pop_front();
          check_val("slv_b_id_o", fld(v, 1), slv_b_id_o[q]);
          check_val("slv_b_resp_o", fld(v, 5), slv_b_resp_o[q]);
          check_val("slv_b_valid_o other port", 0, slv_b_valid_o[NP-1-q]);
          b_seen++;
        end
      end
    end
  end

  // B for each finished burst
  initial begin
    int v;
    forever begin
      @(posedge clk_i);
      #2;
      if (b_pend.size() > 0) begin
        v             = b_pend.pop_front();
        mst_b_valid_i = 1'b1;
        mst_b_id_i    = axi_mux_pkg::mst_id_t'(fld(v, 6));
        mst_b_resp_i  = axi_mux_pkg::resp_t'(fld(v, 5));
        do @(posedge clk_i); while (!mst_b_ready_o);
        #2 mst_b_valid_i = 1'b0;
      end
    end
  end

  // Random back-pressure with W ready only once its AW is known downstream
  initial begin
    forever begin
      @(posedge clk_i);
      #2;
      mst_aw_ready_i   = (lcg_next() % 4) != 0;
      mst_w_ready_i    = (aw_order.size() > 0) && ((lcg_next() % 3) != 0);
      slv_b_ready_i[0] = (lcg_next() % 3) != 0;
      slv_b_ready_i[1] = (lcg_next() % 3) != 0;
    end
  end

  initial begin
    clk_i = 1'b0;
    forever #(PERIOD/2) clk_i = ~clk_i;
  end

  initial begin
    #(NV * 200 * PERIOD);
    $display("Timeout, the writes did not finish within %0d cycles", NV * 200);
    abort_run();
  end

  // Bound assertions count their failures
  initial begin
    wait (i_dut.i_sva.err_count != 0);
    $display("A bound assertion on the master port or the B outputs failed");
    abort_run();
  end

  initial begin
    lcg_state      = 32'd30350;
    rst_i          = 1'b1;
    slv_aw_valid_i = '0;
    slv_aw_id_i    = '0;
    slv_aw_addr_i  = '0;
    slv_aw_len_i   = '0;
    slv_w_valid_i  = '0;
    slv_w_data_i   = '0;
    slv_w_last_i   = '0;
    slv_b_ready_i  = '0;
    mst_aw_ready_i = 1'b0;
    mst_w_ready_i  = 1'b0;
    mst_b_valid_i  = 1'b0;
    mst_b_id_i     = '0;
    mst_b_resp_i   = '0;
    aw_sent        = '{default: 0};
    aw_xfers       = 0;
    w_bursts       = 0;
    b_seen         = 0;
    $readmemh("tb/axi_mux_vectors.txt", vec_mem);
    for (int v = 0; v < NV; v++) begin
      port_vecs[fld(v, 0)].push_back(v);
      aw_exp[fld(v, 0)].push_back(v);
      b_exp[fld(v, 0)].push_back(v);
    end
    repeat (2) @(posedge clk_i);
    #2 rst_i = 1'b0;
    check_val("mst_aw_valid_o", 0, mst_aw_valid_o);
    check_val("mst_w_valid_o", 0, mst_w_valid_o);
    check_val("slv_b_valid_o", 0, slv_b_valid_o);
    fork
      run_port(0);
      run_port(1);
    join_none
    wait (b_seen == NV);
    repeat (4) @(posedge clk_i);
    if (i_dut.i_sva.err_count == 0) begin
      $display("TEST OK");
      $finish;
    end else begin
      $display("%0d assertion failures were seen", i_dut.i_sva.err_count);
      abort_run();
    end
  end

endmodule
